// ==== bench/pwm_generator_tb.sv ====
/*
  self-checking testbench for the four-motor PWM output stage.
  drives throttle writes from an LFSR, models the double-buffered
  store and the frame timing, and measures every pulse at motor_pwm.
  compile with the file list; the run ends by itself.
*/
module pwm_generator_tb;

  import pwm_pkg::*;

  // ====================================================================
  // DUT and clock
  // ====================================================================

  logic                       us_clk;
  logic                       resetn;
  logic                       wr_en;
  logic [motor_sel_width-1:0] wr_sel;
  logic [motor_val_width-1:0] wr_data;
  logic [num_motors-1:0]      motor_pwm;

  pwm_generator uut (
    .us_clk    (us_clk),
    .resetn    (resetn),
    .wr_en     (wr_en),
    .wr_sel    (wr_sel),
    .wr_data   (wr_data),
    .motor_pwm (motor_pwm)
  );

  initial begin
    us_clk = 1'b0;
    forever #10 us_clk = ~us_clk;
  end

  // ====================================================================
  // model and measurement state
  // ====================================================================

  // model frame position and throttle store.
  int m_pc;
  int m_hold [num_motors];
  int m_act [num_motors];
  int cycle;
  // cycle in which the model frame last started.
  int frame_cycle;
  // per-motor pulse measurement.
  logic prev_pwm [num_motors];
  bit   in_pulse [num_motors];
  int   pulse_len [num_motors];
  int   exp_len [num_motors];
  int   last_width [num_motors];
  int   pulse_count [num_motors];
  int   last_rise [num_motors];
  int   prev_rise [num_motors];
  int   rise_count [num_motors];
  // values a test writes to all motors at once.
  int   test_vals [num_motors];
  logic [31:0] lfsr_state;
  int   errors = 0;
  int   checks = 0;
  int   tests_passed = 0;
  int   tests_failed = 0;

  // ====================================================================
  // helpers
  // ====================================================================

  // fibonacci LFSR with taps 32 22 2 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit taken.
  function automatic int random_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = (r << 1) | int'(lfsr_state[0]);
    end
    return r;
  endfunction

  // high time in cycles for a throttle value.
  function automatic int expected_width(input int v);
    int w;
    if (v >= 1 && v <= int'(max_pwm_time_high_us - min_pwm_time_high_us)) begin
      w = int'(min_pwm_time_high_us) + v + 1;
    end else begin
      w = int'(max_pwm_time_high_us) + 1;
    end
    return w;
  endfunction

  task automatic check_value(input string name, input int exp, input int act);
    checks = checks + 1;
    assert (act == exp) else begin
      $display("Fail t=%0t %s: expected %0d, got %0d", $time, name, exp, act);
      errors = errors + 1;
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    if (errors == err_start) begin
      tests_passed = tests_passed + 1;
      $display("test %s: ok", name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %s: %0d error(s)", name, errors - err_start);
    end
  endtask

  // inputs change 1 unit after the rising edge.
  task automatic tick();
    @(posedge us_clk);
    #1;
  endtask

  task automatic do_write(input int sel, input int val);
    wr_en = 1'b1;
    wr_sel = motor_sel_width'(sel);
    wr_data = motor_val_width'(val);
    tick();
    wr_en = 1'b0;
    wr_sel = '0;
    wr_data = '0;
  endtask

  // runs until the model frame position matches.
  task automatic wait_for_pc(input int target);
    int n;
    n = 0;
    while (m_pc != target && n < 2 * int'(pwm_period_us)) begin
      tick();
      n = n + 1;
    end
    if (m_pc != target) begin
      $display("timeout at %0t: frame position %0d never reached", $time, target);
      errors = errors + 1;
    end
  endtask

  // runs until every motor has finished one more pulse.
  task automatic wait_pulse_done();
    int snap [num_motors];
    int n;
    bit done;
    for (int m = 0; m < num_motors; m++) snap[m] = pulse_count[m];
    n = 0;
    done = 1'b0;
    while (!done && n < 2 * int'(pwm_period_us)) begin
      tick();
      n = n + 1;
      done = 1'b1;
      for (int m = 0; m < num_motors; m++) begin
        if (pulse_count[m] == snap[m]) done = 1'b0;
      end
    end
    if (!done) begin
      $display("timeout at %0t: a motor finished no pulse in time", $time);
      errors = errors + 1;
    end
  endtask

  // writes test_vals mid-frame, then checks the next frame's pulses.
  task automatic write_all_and_check();
    wait_for_pc(random_bits(15) % 19990);
    for (int m = 0; m < num_motors; m++) do_write(m, test_vals[m]);
    wait_for_pc(0);
    wait_pulse_done();
    for (int m = 0; m < num_motors; m++) begin
      check_value($sformatf("motor_pwm[%0d] width", m), expected_width(test_vals[m]),
                  last_width[m]);
    end
  endtask

  // ====================================================================
  // monitor and model, sampled mid-cycle
  // ====================================================================

  always @(negedge us_clk) begin : monitor
    logic cur;
    cycle = cycle + 1;
    assert (!$isunknown(motor_pwm)) else begin
      $display("error at %0t: motor_pwm has unknown bits", $time);
      errors = errors + 1;
    end
    if (!resetn) begin
      check_value("motor_pwm in reset", 0, int'(motor_pwm));
      m_pc = 0;
      for (int m = 0; m < num_motors; m++) begin
        m_hold[m] = 0;
        m_act[m] = 0;
        prev_pwm[m] = 1'b0;
        in_pulse[m] = 1'b0;
        rise_count[m] = 0;
      end
    end else begin
      // frame start as the model sees it.
      if (m_pc == 0) begin
        frame_cycle = cycle;
      end
      for (int m = 0; m < num_motors; m++) begin
        cur = motor_pwm[m];
        if (cur && !prev_pwm[m]) begin
          // every rise sits on frame position 0.
          check_value($sformatf("motor_pwm[%0d] rise position", m), 0, m_pc);
          if (rise_count[m] > 0) begin
            check_value($sformatf("motor_pwm[%0d] rise spacing", m),
                        int'(pwm_period_us) + 1, cycle - last_rise[m]);
          end
          prev_rise[m] = last_rise[m];
          last_rise[m] = cycle;
          rise_count[m] = rise_count[m] + 1;
          pulse_len[m] = 1;
          exp_len[m] = expected_width(m_act[m]);
          in_pulse[m] = 1'b1;
        end else if (cur && in_pulse[m]) begin
          pulse_len[m] = pulse_len[m] + 1;
        end else if (!cur && in_pulse[m]) begin
          check_value($sformatf("motor_pwm[%0d] width", m), exp_len[m], pulse_len[m]);
          last_width[m] = pulse_len[m];
          pulse_count[m] = pulse_count[m] + 1;
          in_pulse[m] = 1'b0;
        end
        prev_pwm[m] = cur;
      end
      // next edge. active copies the old holding value first.
      if (m_pc == int'(pwm_period_us)) begin
        for (int m = 0; m < num_motors; m++) m_act[m] = m_hold[m];
        m_pc = 0;
      end else begin
        m_pc = m_pc + 1;
      end
      if (wr_en) m_hold[wr_sel] = int'(wr_data);
    end
  end

  // ====================================================================
  // tests
  // ====================================================================

  task automatic test_reset_default();
    int err0;
    err0 = errors;
    repeat (4) begin
      tick();
      check_value("motor_pwm in reset", 0, int'(motor_pwm));
    end
    resetn = 1'b1;
    wait_pulse_done();
    for (int m = 0; m < num_motors; m++) begin
      check_value($sformatf("motor_pwm[%0d] width", m), int'(max_pwm_time_high_us) + 1,
                  last_width[m]);
    end
    report_test("reset and default width", err0);
  endtask

  task automatic test_random_in_range();
    int err0;
    bit dup;
    err0 = errors;
    for (int r = 0; r < 3; r++) begin
      // distinct values, so the motors differ in the same frame.
      for (int m = 0; m < num_motors; m++) begin
        do begin
          test_vals[m] = random_bits(10) % 1000 + 1;
          dup = 1'b0;
          for (int k = 0; k < m; k++) if (test_vals[k] == test_vals[m]) dup = 1'b1;
        end while (dup);
      end
      write_all_and_check();
    end
    report_test("random throttle 1 to 1000", err0);
  endtask

  task automatic test_out_of_range();
    int err0;
    err0 = errors;
    for (int r = 0; r < 2; r++) begin
      for (int m = 0; m < num_motors; m++) begin
        test_vals[m] = ((m % 2) == r) ? 0 : 1001 + random_bits(5) % 23;
      end
      write_all_and_check();
    end
    report_test("zero and over-range throttle", err0);
  endtask

  task automatic test_mid_period_write();
    int err0;
    int m;
    int v_old;
    int v_a;
    int v_b;
    int v_c;
    err0 = errors;
    m = random_bits(2);
    v_old = random_bits(10) % 1000 + 1;
    v_a = v_old;
    while (v_a == v_old) v_a = random_bits(10) % 1000 + 1;
    v_b = v_a;
    while (v_b == v_a) v_b = random_bits(10) % 1000 + 1;
    v_c = v_b;
    while (v_c == v_b) v_c = random_bits(10) % 1000 + 1;
    wait_for_pc(10000);
    do_write(m, v_old);
    wait_for_pc(0);
    // running pulse keeps the old value.
    wait_for_pc(500);
    do_write(m, v_a);
    wait_pulse_done();
    check_value($sformatf("motor_pwm[%0d] width", m), expected_width(v_old), last_width[m]);
    // second write in the frame replaces the first.
    wait_for_pc(15000);
    do_write(m, v_b);
    // this one lands with the end strobe, so it waits a frame.
    wait_for_pc(int'(pwm_period_us));
    do_write(m, v_c);
    wait_pulse_done();
    check_value($sformatf("motor_pwm[%0d] width", m), expected_width(v_b), last_width[m]);
    wait_for_pc(0);
    wait_pulse_done();
    check_value($sformatf("motor_pwm[%0d] width", m), expected_width(v_c), last_width[m]);
    report_test("mid-frame writes", err0);
  endtask

  task automatic test_rise_alignment();
    int err0;
    err0 = errors;
    for (int f = 0; f < 2; f++) begin
      // widths keep changing while edges are watched.
      wait_for_pc(5000);
      do_write(random_bits(2), random_bits(10));
      wait_for_pc(100);
      for (int m = 0; m < num_motors; m++) begin
        check_value($sformatf("motor_pwm[%0d] rise cycle", m), frame_cycle, last_rise[m]);
        check_value($sformatf("motor_pwm[%0d] rise spacing", m), int'(pwm_period_us) + 1,
                    last_rise[m] - prev_rise[m]);
      end
    end
    report_test("rise alignment and spacing", err0);
  endtask

  task automatic test_reset_mid_pulse();
    int err0;
    err0 = errors;
    // well inside the minimum time, so every output is high.
    wait_for_pc(500);
    check_value("motor_pwm before reset", (1 << num_motors) - 1, int'(motor_pwm));
    resetn = 1'b0;
    #1;
    check_value("motor_pwm at reset", 0, int'(motor_pwm));
    repeat (4) tick();
    resetn = 1'b1;
    wait_pulse_done();
    for (int m = 0; m < num_motors; m++) begin
      check_value($sformatf("motor_pwm[%0d] width", m), int'(max_pwm_time_high_us) + 1,
                  last_width[m]);
    end
    report_test("reset mid-pulse", err0);
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================

  initial begin
    resetn = 1'b0;
    wr_en = 1'b0;
    wr_sel = '0;
    wr_data = '0;
    lfsr_state = 32'h8d2a32e0;
    m_pc = 0;
    cycle = 0;
    frame_cycle = 0;
    for (int m = 0; m < num_motors; m++) begin
      pulse_count[m] = 0;
      last_width[m] = 0;
      last_rise[m] = 0;
      prev_rise[m] = 0;
    end
    test_reset_default();
    test_random_in_range();
    test_out_of_range();
    test_mid_period_write();
    test_rise_alignment();
    test_reset_mid_pulse();
    $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== design/motor_value_latch.sv ====
/*
  double-buffered throttle store for the four motors.
  writes go to holding registers at any time; all active registers
  take their holding values together on the end-of-frame strobe, so
  a pulse in flight never sees a new value.
*/
module motor_value_latch (
  input  logic                                us_clk,
  input  logic                                resetn,
  input  logic                                wr_en,
  input  logic [pwm_pkg::motor_sel_width-1:0] wr_sel,
  input  logic [pwm_pkg::motor_val_width-1:0] wr_data,
  input  logic                                period_last,
  output logic [pwm_pkg::motor_val_width-1:0] active_val0,
  output logic [pwm_pkg::motor_val_width-1:0] active_val1,
  output logic [pwm_pkg::motor_val_width-1:0] active_val2,
  output logic [pwm_pkg::motor_val_width-1:0] active_val3
);

  import pwm_pkg::*;

  // ====================================================================
  // storage
  // ====================================================================

  // written by the bus side.
  logic [motor_val_width-1:0] hold_val [num_motors];

  // seen by the generators.
  logic [motor_val_width-1:0] act_val [num_motors];

  // ====================================================================
  // holding registers
  // ====================================================================

  // no back-pressure; a later write to the same motor wins.
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < num_motors; i++) begin
        hold_val[i] <= '0;
      end
    end else if (wr_en) begin
      hold_val[wr_sel] <= wr_data;
    end
  end

  // ====================================================================
  // active registers
  // ====================================================================

  // all motors switch on the same edge.
  // a write on this edge waits one more frame.
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < num_motors; i++) begin
        act_val[i] <= '0;
      end
    end else if (period_last) begin
      for (int i = 0; i < num_motors; i++) begin
        act_val[i] <= hold_val[i];
      end
    end
  end

  // one output per motor.
  assign active_val0 = act_val[0];
  assign active_val1 = act_val[1];
  assign active_val2 = act_val[2];
  assign active_val3 = act_val[3];

  // ====================================================================
  // checks
  // ====================================================================

  // select must be known whenever a write is strobed.
  a_sel_known: assert property (
    @(posedge us_clk) disable iff (!resetn)
    wr_en |-> !$isunknown(wr_sel)
  ) else $error("write strobe with unknown motor select.");

endmodule

// ==== design/pwm_generator.sv ====
/*
  four-motor PWM output stage, top level.
  a shared timebase drives four pulse generators; throttle writes
  come in on a one-cycle strobe with select and data and take effect
  from the frame after the next end-of-frame strobe.
*/
module pwm_generator (
  input  logic                                us_clk,
  input  logic                                resetn,
  input  logic                                wr_en,
  input  logic [pwm_pkg::motor_sel_width-1:0] wr_sel,
  input  logic [pwm_pkg::motor_val_width-1:0] wr_data,
  output logic [pwm_pkg::num_motors-1:0]      motor_pwm
);

  import pwm_pkg::*;

  // ====================================================================
  // internal nets
  // ====================================================================

  // shared timebase.
  logic [period_width-1:0]    period_counter;
  logic [motor_val_width-1:0] high_counter;
  logic                       period_last;

  // per-motor active throttle.
  logic [motor_val_width-1:0] active_val0;
  logic [motor_val_width-1:0] active_val1;
  logic [motor_val_width-1:0] active_val2;
  logic [motor_val_width-1:0] active_val3;

  // ====================================================================
  // timebase and throttle store
  // ====================================================================

  pwm_timebase u_timebase (
    .us_clk         (us_clk),
    .resetn         (resetn),
    .period_counter (period_counter),
    .high_counter   (high_counter),
    .period_last    (period_last)
  );

  motor_value_latch u_latch (
    .us_clk      (us_clk),
    .resetn      (resetn),
    .wr_en       (wr_en),
    .wr_sel      (wr_sel),
    .wr_data     (wr_data),
    .period_last (period_last),
    .active_val0 (active_val0),
    .active_val1 (active_val1),
    .active_val2 (active_val2),
    .active_val3 (active_val3)
  );

  // ====================================================================
  // generators, one per motor
  // ====================================================================

  pwm_generator_block gen0 (
    .us_clk (us_clk), .resetn (resetn), .motor_val (active_val0),
    .period_counter (period_counter), .high_counter (high_counter),
    .motor_pwm (motor_pwm[0])
  );

  pwm_generator_block gen1 (
    .us_clk (us_clk), .resetn (resetn), .motor_val (active_val1),
    .period_counter (period_counter), .high_counter (high_counter),
    .motor_pwm (motor_pwm[1])
  );

  pwm_generator_block gen2 (
    .us_clk (us_clk), .resetn (resetn), .motor_val (active_val2),
    .period_counter (period_counter), .high_counter (high_counter),
    .motor_pwm (motor_pwm[2])
  );

  pwm_generator_block gen3 (
    .us_clk (us_clk), .resetn (resetn), .motor_val (active_val3),
    .period_counter (period_counter), .high_counter (high_counter),
    .motor_pwm (motor_pwm[3])
  );

endmodule

// ==== design/pwm_generator_block.sv ====
/*
  single-motor pulse generator.
  rises at the start of each frame, stays high for the minimum time
  plus the active throttle value, capped at the maximum time, then
  holds low until the frame ends. one instance per motor.
*/
module pwm_generator_block (
  input  logic                                us_clk,
  input  logic                                resetn,
  input  logic [pwm_pkg::motor_val_width-1:0] motor_val,
  input  logic [pwm_pkg::period_width-1:0]    period_counter,
  input  logic [pwm_pkg::motor_val_width-1:0] high_counter,
  output logic                                motor_pwm
);

  import pwm_pkg::*;

  // ====================================================================
  // state register
  // ====================================================================

  pwm_state_t state;
  pwm_state_t next_state;

  // reset lands in min count, so the pulse starts with the frame.
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      state <= st_min_count;
    end else begin
      state <= next_state;
    end
  end

  // ====================================================================
  // next state
  // ====================================================================

  always_comb begin
    next_state = state;
    case (state)
      // fixed minimum part of the pulse.
      st_min_count: begin
        if (period_counter == min_pwm_time_high_us) begin
          next_state = st_pwm_count;
        end
      end
      // throttle part; ends on a match or at the hard cap.
      // a value of 0 never matches, so it runs to the cap.
      st_pwm_count: begin
        if ((high_counter == motor_val) ||
            (period_counter == max_pwm_time_high_us)) begin
          next_state = st_low_count;
        end
      end
      // low for the rest of the frame.
      st_low_count: begin
        if (period_counter == pwm_period_us) begin
          next_state = st_min_count;
        end
      end
      // illegal codes recover at the next frame start.
      default: begin
        next_state = st_min_count;
      end
    endcase
  end

  // ====================================================================
  // output
  // ====================================================================

  // high in min and pwm count, one bit each in the one-hot code.
  // held low while in reset.
  assign motor_pwm = resetn & (state[0] | state[1]);

  // ====================================================================
  // checks
  // ====================================================================

  a_state_onehot: assert property (
    @(posedge us_clk) disable iff (!resetn)
    $onehot(state)
  ) else $error("generator state not one-hot.");

  // pulse never outlives the cap, whatever the throttle.
  a_low_past_max: assert property (
    @(posedge us_clk) disable iff (!resetn)
    (period_counter > max_pwm_time_high_us) |-> !motor_pwm
  ) else $error("pulse still high past max high time.");

endmodule

// ==== design/pwm_pkg.sv ====
/*
  shared constants and types for the four-motor PWM output stage.
  every design file takes what it needs from here by wildcard import,
  and port widths use scoped names from this package.
*/
package pwm_pkg;

  // ====================================================================
  // widths
  // ====================================================================

  // throttle value width, also the width of the high-time counter.
  localparam int motor_val_width = 10;

  // microsecond period counter width.
  localparam int period_width = 16;

  // number of motor outputs.
  localparam int num_motors = 4;

  // write select width, one code per motor.
  localparam int motor_sel_width = 2;

  // ====================================================================
  // timing, all in microseconds (one us_clk cycle each)
  // ====================================================================

  // every pulse stays high at least this long.
  localparam logic [period_width-1:0] min_pwm_time_high_us = 16'd1000;

  // hard cap on the high time.
  localparam logic [period_width-1:0] max_pwm_time_high_us = 16'd2000;

  // last count of the frame, so a frame is one cycle longer than this.
  localparam logic [period_width-1:0] pwm_period_us = 16'd20000;

  // ====================================================================
  // generator state
  // ====================================================================

  // one-hot, so the output decode is a single or of two bits.
  typedef enum logic [2:0] {
    st_min_count = 3'b001,
    st_pwm_count = 3'b010,
    st_low_count = 3'b100
  } pwm_state_t;

endpackage

// ==== design/pwm_timebase.sv ====
/*
  shared microsecond timebase for all motor outputs.
  runs a free frame counter, a saturating counter of time past the
  minimum high time, and a one-cycle strobe on the last frame count.
*/
module pwm_timebase (
  input  logic                                us_clk,
  input  logic                                resetn,
  output logic [pwm_pkg::period_width-1:0]    period_counter,
  output logic [pwm_pkg::motor_val_width-1:0] high_counter,
  output logic                                period_last
);

  import pwm_pkg::*;

  // ====================================================================
  // frame counter
  // ====================================================================

  // strobe on the final count of the frame.
  assign period_last = (period_counter == pwm_period_us);

  // counts 0 .. pwm_period_us, then wraps.
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      period_counter <= '0;
    end else if (period_last) begin
      period_counter <= '0;
    end else begin
      period_counter <= period_counter + 1'b1;
    end
  end

  // ====================================================================
  // high-time counter
  // ====================================================================

  // time past the minimum high time.
  // steps on the edge that leaves min count, so it reads 1 when
  // period_counter reads min + 1.
  // saturates at all ones, well past the max high time.
  // throttle compare in each block stays 10 bits wide.
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      high_counter <= '0;
    end else if (period_last) begin
      // restarts together with the period counter.
      high_counter <= '0;
    end else if ((period_counter >= min_pwm_time_high_us) &&
                 (high_counter != '1)) begin
      high_counter <= high_counter + 1'b1;
    end
  end

  // ====================================================================
  // checks
  // ====================================================================

  // frame counter never runs past the end of frame.
  a_period_in_range: assert property (
    @(posedge us_clk) disable iff (!resetn)
    period_counter <= pwm_period_us
  ) else $error("period counter above end of frame.");

endmodule

// ==== pwm_generator.f ====
design/pwm_pkg.sv
design/pwm_timebase.sv
design/motor_value_latch.sv
design/pwm_generator_block.sv
design/pwm_generator.sv
bench/pwm_generator_tb.sv
